/* source/mext_pkg.sv */
package mext_pkg;

    localparam int WORD_W = 32;
    localparam int REG_W  = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_addr_t;

    // Encodings follow funct3 of the M extension.
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } mext_op_e;

    typedef struct packed {
        mext_op_e  op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      we;
    } mext_req_t;

    // One entry per pipeline stage, operands already read.
    typedef struct packed {
        mext_op_e  op;
        word_t     src_a;
        word_t     src_b;
        reg_addr_t rd;
        logic      we;
    } mext_entry_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

endpackage

/* source/mext_regfile.sv */
module mext_regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  mext_pkg::reg_addr_t rs1_addr_i,
    input  mext_pkg::reg_addr_t rs2_addr_i,
    output mext_pkg::word_t     rs1_data_o,
    output mext_pkg::word_t     rs2_data_o,
    input  logic                wb_valid_i,
    input  mext_pkg::rf_write_t wb_i,
    input  logic                ld_valid_i,
    input  mext_pkg::rf_write_t ld_i
);
    import mext_pkg::*;

    // Register x0 has no storage.
    word_t regs_q [31:1];

    logic ld_en;
    logic wb_en;

    assign ld_en = ld_valid_i && ld_i.we && (ld_i.addr != '0);
    assign wb_en = wb_valid_i && wb_i.we && (wb_i.addr != '0);

    // The writeback comes last so that it overrides a load to the same register.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (ld_en) begin
                regs_q[ld_i.addr] <= ld_i.data;
            end
            if (wb_en) begin
                regs_q[wb_i.addr] <= wb_i.data;
            end
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

/* source/mext_issue_unit.sv */
module mext_issue_unit #(
    parameter int PIPE_DEPTH = 5
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  req_valid_i,
    input  mext_pkg::mext_req_t                   req_i,
    input  logic [PIPE_DEPTH-1:0]                 inflight_valid_i,
    input  mext_pkg::reg_addr_t [PIPE_DEPTH-1:0]  inflight_rd_i,
    output mext_pkg::reg_addr_t                   rs1_addr_o,
    output mext_pkg::reg_addr_t                   rs2_addr_o,
    input  mext_pkg::word_t                       rs1_data_i,
    input  mext_pkg::word_t                       rs2_data_i,
    output logic                                  issue_valid_o,
    output mext_pkg::mext_entry_t                 issue_o,
    output logic                                  busy_o
);
    import mext_pkg::*;

    logic                  held_valid_q;
    mext_req_t             held_q;
    logic                  cur_valid;
    mext_req_t             cur_req;
    logic [PIPE_DEPTH-1:0] src_hit;
    logic                  hazard;

    // A held request has priority; new strobes are ignored while busy.
    assign cur_valid = held_valid_q || req_valid_i;
    assign cur_req   = held_valid_q ? held_q : req_i;

    always_comb begin
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            src_hit[i] = inflight_valid_i[i] &&
                         (((cur_req.rs1 != '0) && (cur_req.rs1 == inflight_rd_i[i])) ||
                          ((cur_req.rs2 != '0) && (cur_req.rs2 == inflight_rd_i[i])));
        end
    end

    assign hazard = cur_valid && (|src_hit);

    assign rs1_addr_o = cur_req.rs1;
    assign rs2_addr_o = cur_req.rs2;

    // On a hazard stage 1 receives a bubble.
    assign issue_valid_o = cur_valid && !hazard;
    assign issue_o = '{
        op:    cur_req.op,
        src_a: rs1_data_i,
        src_b: rs2_data_i,
        rd:    cur_req.rd,
        we:    cur_req.we
    };

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_valid_q <= 1'b0;
        end else begin
            held_valid_q <= hazard;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hazard) begin
            held_q <= cur_req;
        end
    end

    assign busy_o = held_valid_q;

endmodule

/* source/mext_stage_regs.sv */
module mext_stage_regs #(
    parameter int PIPE_DEPTH = 5
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  issue_valid_i,
    input  mext_pkg::mext_entry_t                 issue_i,
    output logic [PIPE_DEPTH-1:0]                 inflight_valid_o,
    output mext_pkg::reg_addr_t [PIPE_DEPTH-1:0]  inflight_rd_o,
    output logic                                  last_valid_o,
    output mext_pkg::mext_entry_t                 last_o
);
    import mext_pkg::*;

    // Stage g sits at index g; index 0 is stage 1.
    for (genvar g = 0; g < PIPE_DEPTH; g++) begin : g_stage
        logic        valid_d;
        logic        valid_q;
        mext_entry_t entry_d;
        mext_entry_t entry_q;

        if (g == 0) begin : g_head
            assign valid_d = issue_valid_i;
            assign entry_d = issue_i;
        end else begin : g_body
            assign valid_d = g_stage[g-1].valid_q;
            assign entry_d = g_stage[g-1].entry_q;
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= valid_d;
            end
        end

        always_ff @(posedge clk_i) begin
            entry_q <= entry_d;
        end

        // Only stages that will write a register matter for hazards.
        assign inflight_valid_o[g] = valid_q && entry_q.we;
        assign inflight_rd_o[g]    = entry_q.rd;

        if (g == PIPE_DEPTH - 1) begin : g_tail
            assign last_valid_o = valid_q;
            assign last_o       = entry_q;
        end
    end

endmodule

/* source/mext_result_unit.sv */
module mext_result_unit (
    input  logic                  last_valid_i,
    input  mext_pkg::mext_entry_t last_i,
    output logic                  wb_valid_o,
    output mext_pkg::rf_write_t   wb_o
);
    import mext_pkg::*;

    word_t              a;
    word_t              b;
    logic               a_signed;
    logic               b_signed;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] prod;
    logic               div_zero;
    logic               div_ovf;
    word_t              div_b_s;
    word_t              div_b_u;
    word_t              quot_s;
    word_t              rem_s;
    word_t              quot_u;
    word_t              rem_u;
    word_t              result;

    assign a = last_i.src_a;
    assign b = last_i.src_b;

    // One 33x33 signed multiplier serves all four products.
    assign a_signed = (last_i.op == MULH) || (last_i.op == MULHSU);
    assign b_signed = (last_i.op == MULH);
    assign mul_a    = {a_signed & a[31], a};
    assign mul_b    = {b_signed & b[31], b};
    assign prod     = mul_a * mul_b;

    assign div_zero = (b == '0);
    assign div_ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);

    // A divisor of one gives the dividend and a zero remainder, as overflow requires.
    assign div_b_s = (div_zero || div_ovf) ? 32'd1 : b;
    assign div_b_u = div_zero ? 32'd1 : b;

    assign quot_s = $signed(a) / $signed(div_b_s);
    assign rem_s  = $signed(a) % $signed(div_b_s);
    assign quot_u = a / div_b_u;
    assign rem_u  = a % div_b_u;

    always_comb begin
        result = prod[31:0];
        case (last_i.op)
            MUL:    result = prod[31:0];
            MULH,
            MULHSU,
            MULHU:  result = prod[63:32];
            DIV:    result = div_zero ? '1 : quot_s;
            DIVU:   result = div_zero ? '1 : quot_u;
            REM:    result = div_zero ? a : rem_s;
            REMU:   result = div_zero ? a : rem_u;
            default: result = prod[31:0];
        endcase
    end

    assign wb_valid_o = last_valid_i;
    assign wb_o = '{
        we:   last_i.we,
        addr: last_i.rd,
        data: result
    };

endmodule

/* source/mext_unit_top.sv */
module mext_unit_top #(
    parameter int PIPE_DEPTH = 5
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  mext_pkg::mext_req_t req_i,
    input  logic                ld_valid_i,
    input  mext_pkg::rf_write_t ld_i,
    output logic                busy_o,
    output logic                wb_valid_o,
    output mext_pkg::rf_write_t wb_o
);
    import mext_pkg::*;

    reg_addr_t                   rs1_addr;
    reg_addr_t                   rs2_addr;
    word_t                       rs1_data;
    word_t                       rs2_data;
    logic                        issue_valid;
    mext_entry_t                 issue_entry;
    logic [PIPE_DEPTH-1:0]       inflight_valid;
    reg_addr_t [PIPE_DEPTH-1:0]  inflight_rd;
    logic                        last_valid;
    mext_entry_t                 last_entry;

    mext_issue_unit #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_issue (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .inflight_valid_i (inflight_valid),
        .inflight_rd_i    (inflight_rd),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .issue_valid_o    (issue_valid),
        .issue_o          (issue_entry),
        .busy_o           (busy_o)
    );

    mext_stage_regs #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_stages (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .issue_valid_i    (issue_valid),
        .issue_i          (issue_entry),
        .inflight_valid_o (inflight_valid),
        .inflight_rd_o    (inflight_rd),
        .last_valid_o     (last_valid),
        .last_o           (last_entry)
    );

    mext_result_unit u_result (
        .last_valid_i (last_valid),
        .last_i       (last_entry),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

    mext_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_valid_i (wb_valid_o),
        .wb_i       (wb_o),
        .ld_valid_i (ld_valid_i),
        .ld_i       (ld_i)
    );

endmodule

/* tb/mext_tb_model.svh */
`ifndef MEXT_TB_MODEL_SVH
`define MEXT_TB_MODEL_SVH

// Architectural register state as the issuer sees it, in program order.
word_t       shadow_rf [0:31];
logic [31:0] lcg_state;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic word_t next_rand();
    lcg_state = lcg_next(lcg_state);
    return lcg_state;
endfunction

function automatic void shadow_write(input reg_addr_t addr, input word_t data);
    if (addr != '0) begin
        shadow_rf[addr] = data;
    end
endfunction

// RV32M semantics, with the zero divisor and overflow rules of the spec.
function automatic word_t model_result(input mext_op_e op, input word_t a, input word_t b);
    logic [63:0] sext_a;
    logic [63:0] sext_b;
    logic [63:0] zext_b;
    logic [63:0] prod;
    int          sa;
    int          sb;
    logic        ovf;
    sext_a = {{32{a[31]}}, a};
    sext_b = {{32{b[31]}}, b};
    zext_b = {32'h0, b};
    sa = a;
    sb = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        MUL:    prod = sext_a * sext_b;
        MULH:   prod = sext_a * sext_b;
        MULHSU: prod = sext_a * zext_b;
        default: prod = {32'h0, a} * zext_b;
    endcase
    case (op)
        MUL:    return prod[31:0];
        MULH, MULHSU, MULHU: return prod[63:32];
        DIV:    return (b == '0) ? 32'hffff_ffff : (ovf ? a : word_t'(sa / sb));
        DIVU:   return (b == '0) ? 32'hffff_ffff : a / b;
        REM:    return (b == '0) ? a : (ovf ? 32'h0 : word_t'(sa % sb));
        default: return (b == '0) ? a : a % b;
    endcase
endfunction

`endif

/* tb/tb_mext_unit.sv */
module tb_mext_unit;
    import mext_pkg::*;

    `include "mext_tb_model.svh"

    localparam int PIPE_DEPTH = 5;
    localparam int N_RAND     = 48;
    localparam int N_CORNER   = 15;
    localparam int N_PAIRS    = 12;
    localparam int N_STREAM   = 40;
    localparam int N_ZERO     = 4;
    localparam int N_REQ      = N_RAND + N_CORNER + 2 * N_PAIRS + N_STREAM + N_ZERO;
    localparam int TIMEOUT    = 200 + N_REQ * (PIPE_DEPTH + 3) + 100;

    typedef struct packed {
        rf_write_t   wr;
        logic [31:0] strobe_cyc;
        logic        exact;
    } exp_wb_t;

    logic      clk_i;
    logic      rst_n_i;
    logic      req_valid_i;
    mext_req_t req_i;
    logic      ld_valid_i;
    rf_write_t ld_i;
    logic      busy_o;
    logic      wb_valid_o;
    rf_write_t wb_o;

    exp_wb_t     exp_q [$];
    logic [31:0] cyc;
    logic        busy_allowed;
    reg_addr_t   prod_rd;

    mext_unit_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .ld_valid_i  (ld_valid_i),
        .ld_i        (ld_i),
        .busy_o      (busy_o),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string why);
        $display("ERROR: %s", why);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        stop_run();
    endtask

    function automatic reg_addr_t rand_reg(input int base, input int count);
        word_t w;
        int    idx;
        w = next_rand();
        idx = base + int'(w[31:16]) % count;
        return reg_addr_t'(idx);
    endfunction

    function automatic mext_op_e rand_op();
        word_t w;
        w = next_rand();
        return mext_op_e'(w[31:29]);
    endfunction

    task automatic idle_cycle();
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        ld_valid_i  <= 1'b0;
    endtask

    task automatic load_reg(input reg_addr_t addr, input word_t data);
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        ld_valid_i  <= 1'b1;
        ld_i        <= '{we: 1'b1, addr: addr, data: data};
        shadow_write(addr, data);
    endtask

    // The expected value is taken from the shadow file at strobe time, which
    // matches the DUT because operations complete in issue order.
    task automatic send_req(input mext_op_e req_op, input reg_addr_t rs1, input reg_addr_t rs2,
                            input reg_addr_t rd, input logic we, input logic exact);
        mext_req_t r;
        exp_wb_t   e;
        word_t     res;
        r.op  = req_op;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.rd  = rd;
        r.we  = we;
        res = model_result(req_op, shadow_rf[rs1], shadow_rf[rs2]);
        e.wr = '{we: we, addr: rd, data: res};
        e.exact = exact;
        @(posedge clk_i);
        e.strobe_cyc = cyc + 1;
        req_valid_i <= 1'b1;
        req_i       <= r;
        ld_valid_i  <= 1'b0;
        exp_q.push_back(e);
        if (we) begin
            shadow_write(rd, res);
        end
    endtask

    task automatic settle(input logic expect_busy);
        idle_cycle();
        @(negedge clk_i);
        if (expect_busy) begin
            assert (busy_o) else report_error("busy_o did not rise for a dependent request");
        end
        while (busy_o) begin
            @(negedge clk_i);
        end
    endtask

    // One extra idle cycle lets the last writeback land before any load.
    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        idle_cycle();
    endtask

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            report_error("timeout, the run went past its cycle limit");
        end
    end

    always @(negedge clk_i) begin : wb_monitor
        exp_wb_t e;
        if (rst_n_i) begin
            assert (busy_allowed || !busy_o)
                else report_error("busy_o went high with no dependent request");
            if (wb_valid_o) begin
                assert (exp_q.size() > 0)
                    else report_error("writeback seen with no request outstanding");
                e = exp_q.pop_front();
                assert (wb_o.data == e.wr.data)
                    else report_mismatch("wb_o.data", e.wr.data, wb_o.data);
                assert (wb_o.addr == e.wr.addr)
                    else report_mismatch("wb_o.addr", e.wr.addr, wb_o.addr);
                assert (wb_o.we == e.wr.we)
                    else report_mismatch("wb_o.we", e.wr.we, wb_o.we);
                if (e.exact) begin
                    assert (cyc - e.strobe_cyc == PIPE_DEPTH)
                        else report_mismatch("wb latency", PIPE_DEPTH, cyc - e.strobe_cyc);
                end
            end
        end
    end

    initial begin
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        ld_valid_i   = 1'b0;
        ld_i         = '0;
        cyc          = '0;
        busy_allowed = 1'b0;
        lcg_state    = 32'hd76a;
        for (int i = 0; i < 32; i++) begin
            shadow_rf[i] = '0;
        end
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (8) idle_cycle();

        // Sources live in x1..x15 and destinations in x16..x31, so no request depends
        // on another.
        for (int i = 1; i < 32; i++) begin
            load_reg(reg_addr_t'(i), next_rand() >> (next_rand() >> 27));
        end
        for (int i = 0; i < N_RAND; i++) begin
            send_req(mext_op_e'(i % 8), rand_reg(1, 15), rand_reg(1, 15),
                     rand_reg(16, 16), 1'b1, 1'b1);
            repeat (int'(next_rand() >> 30)) idle_cycle();
        end
        drain();

        load_reg(5'd1, 32'h0000_0000);
        load_reg(5'd2, 32'h8000_0000);
        load_reg(5'd3, 32'hffff_ffff);
        load_reg(5'd4, 32'h7fff_ffff);
        load_reg(5'd5, 32'h0000_0001);
        load_reg(5'd6, next_rand() | 32'h1);
        send_req(DIV, 5'd6, 5'd1, 5'd16, 1'b1, 1'b1);
        send_req(DIVU, 5'd6, 5'd1, 5'd17, 1'b1, 1'b1);
        send_req(REM, 5'd6, 5'd1, 5'd18, 1'b1, 1'b1);
        send_req(REMU, 5'd6, 5'd1, 5'd19, 1'b1, 1'b1);
        send_req(DIV, 5'd2, 5'd3, 5'd20, 1'b1, 1'b1);
        send_req(REM, 5'd2, 5'd3, 5'd21, 1'b1, 1'b1);
        send_req(DIVU, 5'd2, 5'd3, 5'd22, 1'b1, 1'b1);
        send_req(REMU, 5'd2, 5'd3, 5'd23, 1'b1, 1'b1);
        send_req(MULH, 5'd2, 5'd2, 5'd24, 1'b1, 1'b1);
        send_req(MULH, 5'd2, 5'd3, 5'd25, 1'b1, 1'b1);
        send_req(MULH, 5'd4, 5'd2, 5'd26, 1'b1, 1'b1);
        send_req(MULHSU, 5'd3, 5'd3, 5'd27, 1'b1, 1'b1);
        send_req(MULHSU, 5'd2, 5'd3, 5'd28, 1'b1, 1'b1);
        send_req(MULHU, 5'd3, 5'd3, 5'd29, 1'b1, 1'b1);
        send_req(MULHU, 5'd2, 5'd4, 5'd30, 1'b1, 1'b1);
        drain();

        // The consumer follows its producer by one cycle and must be held.
        busy_allowed = 1'b1;
        for (int i = 0; i < N_PAIRS; i++) begin
            prod_rd = rand_reg(16, 16);
            send_req(rand_op(), rand_reg(1, 15), rand_reg(1, 15), prod_rd, 1'b1, 1'b1);
            if (i % 2 == 0) begin
                send_req(rand_op(), prod_rd, rand_reg(1, 31), rand_reg(1, 31), 1'b1, 1'b0);
            end else begin
                send_req(rand_op(), rand_reg(1, 31), prod_rd, rand_reg(1, 31), 1'b1, 1'b0);
            end
            settle(1'b1);
            drain();
        end
        busy_allowed = 1'b0;

        for (int i = 0; i < N_STREAM; i++) begin
            send_req(rand_op(), rand_reg(1, 15), rand_reg(1, 15), rand_reg(16, 16),
                     1'b1, 1'b1);
        end
        drain();

        send_req(MUL, 5'd6, 5'd5, 5'd0, 1'b1, 1'b1);
        send_req(MULHU, 5'd0, 5'd6, 5'd20, 1'b1, 1'b1);
        send_req(DIVU, 5'd6, 5'd5, 5'd7, 1'b0, 1'b1);
        send_req(REMU, 5'd7, 5'd6, 5'd21, 1'b1, 1'b1);

        // None of these requests waits on another, so each one completes
        // PIPE_DEPTH cycles after its strobe.
        repeat (PIPE_DEPTH + 2) idle_cycle();

        if (exp_q.size() != 0) begin
            report_error("writebacks still outstanding at the end of the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+tb
source/mext_pkg.sv
source/mext_regfile.sv
source/mext_issue_unit.sv
source/mext_stage_regs.sv
source/mext_result_unit.sv
source/mext_unit_top.sv
tb/tb_mext_unit.sv
